/* verilog/aes_settings.svh */
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// bus and block geometry
//////////////////////////////////////////////////////////////////////

// one text, key or output word on the wire
`define AES_WORD_W 32

// full cipher block and key size
`define AES_BLOCK_W 128

// load and output both take one cycle per word
`define AES_WORDS_PER_BLOCK 4

//////////////////////////////////////////////////////////////////////
// cipher
//////////////////////////////////////////////////////////////////////

`define AES_NUM_ROUNDS 10 // aes-128 only

`endif

/* verilog/aes_pkg.sv */
`default_nettype none

`include "aes_settings.svh"

package aes_pkg;

    //////////////////////////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0] aes_byte_t;
    typedef logic [`AES_WORD_W-1:0] aes_word_t;
    typedef logic [`AES_BLOCK_W-1:0] aes_block_t; // word 0 sits in the top bits

    // one state column, seen whole or byte by byte
    // bytes[0] is the most significant byte
    typedef union packed {
        aes_word_t word;
        aes_byte_t [0:3] bytes;
    } aes_column_u;

    // counts 0 (idle) up to the last round
    typedef logic [$clog2(`AES_NUM_ROUNDS + 1)-1:0] aes_round_t;

    //////////////////////////////////////////////////////////////////////
    // forward s-box
    //////////////////////////////////////////////////////////////////////

    // entry 0 in the top byte so the byte value indexes straight in
    localparam logic [0:255][7:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // byte substitution shared by the round engine and the key schedule
    function automatic aes_byte_t aes_sbox(input aes_byte_t b);
        return sbox_table[b];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // gf(2^8) arithmetic
    //////////////////////////////////////////////////////////////////////

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aes_byte_t aes_xtime(input aes_byte_t b);
        aes_byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ 8'h1b; // reduce the carried-out bit
        end
        return shifted;
    endfunction

endpackage

`default_nettype wire

/* verilog/aes_block_loader.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_block_loader (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    input  wire aes_pkg::aes_word_t  input_text,
    input  wire aes_pkg::aes_word_t  input_key,
    input  wire                      result_valid,
    output logic                     block_valid,
    output aes_pkg::aes_block_t      block_text,
    output aes_pkg::aes_block_t      block_key
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_wait
    } load_state_t;

    load_state_t state;
    logic [$clog2(`AES_WORDS_PER_BLOCK)-1:0] word_cnt;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            word_cnt    <= '0;
            block_valid <= 1'b0;
        end else begin
            block_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_load;
                        word_cnt <= '0;
                    end
                end
                st_load: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == `AES_WORDS_PER_BLOCK - 1) begin
                        block_valid <= 1'b1; // last word lands this edge
                        state       <= st_wait;
                    end
                end
                st_wait: begin
                    // the cycle that frees the core may already carry the next start
                    if (result_valid) begin
                        state    <= start ? st_load : st_idle;
                        word_cnt <= '0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // first word ends up in the top bits
    always_ff @(posedge clk) begin
        if (state == st_load) begin
            block_text <= {block_text[`AES_BLOCK_W-`AES_WORD_W-1:0], input_text};
            block_key  <= {block_key[`AES_BLOCK_W-`AES_WORD_W-1:0], input_key};
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        block_valid |=> !block_valid)
        else $error("block_valid held for more than one cycle");

endmodule

`default_nettype wire

/* verilog/aes_key_schedule.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_key_schedule (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      block_valid,
    input  wire aes_pkg::aes_block_t block_key,
    input  wire                      key_advance,
    output aes_pkg::aes_block_t      round_key
);

    import aes_pkg::*;

    aes_block_t  key_q;   // key of the previous round
    aes_byte_t   rcon_q;
    aes_column_u last_col;
    aes_column_u sub_col;
    aes_word_t   key_w [`AES_WORDS_PER_BLOCK];
    aes_word_t   next_w [`AES_WORDS_PER_BLOCK];

    always_ff @(posedge clk) begin
        if (block_valid) begin
            key_q <= block_key; // cipher key acts as round 0
        end else if (key_advance) begin
            key_q <= round_key;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rcon_q <= 8'h01;
        end else if (block_valid) begin
            rcon_q <= 8'h01;
        end else if (key_advance) begin
            rcon_q <= aes_xtime(rcon_q); // 01 02 04 .. 1b 36
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next round key
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `AES_WORDS_PER_BLOCK; i++) begin
            key_w[i] = key_q[`AES_BLOCK_W-1-`AES_WORD_W*i -: `AES_WORD_W];
        end
        // rotword folded into the byte pick, then subword
        last_col.word = key_w[`AES_WORDS_PER_BLOCK-1];
        for (int b = 0; b < 4; b++) begin
            sub_col.bytes[b] = aes_sbox(last_col.bytes[(b + 1) % 4]);
        end
        next_w[0] = key_w[0] ^ sub_col.word ^ {rcon_q, {(`AES_WORD_W-8){1'b0}}};
        for (int i = 1; i < `AES_WORDS_PER_BLOCK; i++) begin
            next_w[i] = key_w[i] ^ next_w[i-1]; // chained xor
        end
        for (int i = 0; i < `AES_WORDS_PER_BLOCK; i++) begin
            round_key[`AES_BLOCK_W-1-`AES_WORD_W*i -: `AES_WORD_W] = next_w[i];
        end
    end

    a_no_advance_on_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(key_advance && block_valid))
        else $error("key advanced while a new key was being loaded");

endmodule

`default_nettype wire

/* verilog/aes_round_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_round_engine (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      block_valid,
    input  wire aes_pkg::aes_block_t block_text,
    input  wire aes_pkg::aes_block_t block_key,
    input  wire aes_pkg::aes_block_t round_key,
    output logic                     key_advance,
    output logic                     result_valid,
    output aes_pkg::aes_block_t      result_block
);

    import aes_pkg::*;

    aes_block_t state_q;
    aes_round_t round_cnt; // 0 when idle, else the round computed this cycle
    aes_block_t shifted;
    aes_block_t mixed;
    aes_block_t round_out;
    logic       last_round;

    //////////////////////////////////////////////////////////////////////
    // round datapath
    //////////////////////////////////////////////////////////////////////

    // subbytes and shiftrows together
    always_comb begin : sub_shift
        int src;
        for (int c = 0; c < `AES_WORDS_PER_BLOCK; c++) begin
            for (int r = 0; r < 4; r++) begin
                src = 4 * ((c + r) % 4) + r; // row r rotates left by r
                shifted[`AES_BLOCK_W-1-8*(4*c+r) -: 8] =
                    aes_sbox(state_q[`AES_BLOCK_W-1-8*src -: 8]);
            end
        end
    end

    always_comb begin : mix_columns
        aes_column_u col_in;
        aes_column_u col_out;
        for (int c = 0; c < `AES_WORDS_PER_BLOCK; c++) begin
            col_in.word = shifted[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W];
            for (int r = 0; r < 4; r++) begin
                // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
                col_out.bytes[r] = aes_xtime(col_in.bytes[r])
                                 ^ aes_xtime(col_in.bytes[(r + 1) % 4])
                                 ^ col_in.bytes[(r + 1) % 4]
                                 ^ col_in.bytes[(r + 2) % 4]
                                 ^ col_in.bytes[(r + 3) % 4];
            end
            mixed[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W] = col_out.word;
        end
    end

    assign last_round   = (round_cnt == `AES_NUM_ROUNDS);
    assign round_out    = (last_round ? shifted : mixed) ^ round_key; // no mix in round 10
    assign key_advance  = (round_cnt != '0);
    assign result_block = state_q;

    always_ff @(posedge clk) begin
        if (block_valid) begin
            state_q <= block_text ^ block_key; // initial addroundkey
        end else if (key_advance) begin
            state_q <= round_out;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // round control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_cnt    <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (block_valid) begin
                round_cnt <= 4'd1;
            end else if (last_round) begin
                round_cnt    <= '0;
                result_valid <= 1'b1;
            end else if (key_advance) begin
                round_cnt <= round_cnt + 4'd1;
            end
        end
    end

    a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
        round_cnt <= `AES_NUM_ROUNDS)
        else $error("round counter ran past the last round");

    // loader handoff to result takes the full round sequence
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        block_valid |-> ##(`AES_NUM_ROUNDS + 1) result_valid)
        else $error("result_valid missing after a loaded block");

endmodule

`default_nettype wire

/* verilog/aes_output_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_output_serializer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      result_valid,
    input  wire aes_pkg::aes_block_t result_block,
    output logic                     done,
    output aes_pkg::aes_word_t       output_text
);

    import aes_pkg::*;

    aes_block_t shift_q;
    logic [$clog2(`AES_WORDS_PER_BLOCK)-1:0] word_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done     <= 1'b0;
            word_cnt <= '0;
        end else if (result_valid) begin
            done     <= 1'b1;
            word_cnt <= '0;
        end else if (done) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == `AES_WORDS_PER_BLOCK - 1) begin
                done <= 1'b0; // last word shown
            end
        end
    end

    // word 0 first, next word moves up each cycle
    always_ff @(posedge clk) begin
        if (result_valid) begin
            shift_q <= result_block;
        end else if (done) begin
            shift_q <= {shift_q[`AES_BLOCK_W-`AES_WORD_W-1:0], {`AES_WORD_W{1'b0}}};
        end
    end

    assign output_text = done ? shift_q[`AES_BLOCK_W-1 -: `AES_WORD_W] : '0;

    a_done_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> done [*`AES_WORDS_PER_BLOCK] ##1 !done)
        else $error("done window has the wrong length");

endmodule

`default_nettype wire

/* verilog/aes_encrypt_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_encrypt_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,      // one cycle ahead of the first word
    input  wire aes_pkg::aes_word_t input_text,
    input  wire aes_pkg::aes_word_t input_key,
    output wire                     done,
    output wire aes_pkg::aes_word_t output_text
);

    import aes_pkg::*;

    wire        block_valid;
    aes_block_t block_text;
    aes_block_t block_key;
    aes_block_t round_key;
    wire        key_advance;
    wire        result_valid;
    aes_block_t result_block;

    //////////////////////////////////////////////////////////////////////
    // input, cipher core, output
    //////////////////////////////////////////////////////////////////////

    aes_block_loader block_loader_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .input_text   (input_text),
        .input_key    (input_key),
        .result_valid (result_valid),  // frees the loader for the next block
        .block_valid  (block_valid),
        .block_text   (block_text),
        .block_key    (block_key)
    );

    aes_round_engine round_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .block_valid  (block_valid),
        .block_text   (block_text),
        .block_key    (block_key),
        .round_key    (round_key),
        .key_advance  (key_advance),
        .result_valid (result_valid),
        .result_block (result_block)
    );

    aes_key_schedule key_schedule_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .block_key   (block_key),
        .key_advance (key_advance),
        .round_key   (round_key)
    );

    aes_output_serializer output_serializer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .result_block (result_block),
        .done         (done),
        .output_text  (output_text)
    );

endmodule

`default_nettype wire

/* testbench/aes_encrypt_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module aes_encrypt_tb;

    import aes_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;    // after the rising edge
    localparam int RESULT_LATENCY  = 16;   // start edge to first output word
    localparam int WATCHDOG_CYCLES = 5 * 60;

    // fips-197 appendix c.1
    localparam aes_block_t C1_KEY    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t C1_TEXT   = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t C1_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    // fips-197 appendix b
    localparam aes_block_t B_KEY     = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_block_t B_TEXT    = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_block_t B_CIPHER  = 128'h3925841d02dc09fbdc118597196a0b32;

    logic           clk;
    logic           rst_n;
    logic           start;
    aes_word_t      input_text;
    aes_word_t      input_key;
    wire            done;
    wire aes_word_t output_text;

    int          cycle_cnt    = 0;
    int          num_checks   = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic [15:0] lfsr_q       = 16'd30316;

    aes_encrypt_top aes_encrypt_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .input_text  (input_text),
        .input_key   (input_key),
        .done        (done),
        .output_text (output_text)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | lfsr_q[0];
        end
    endtask

    // word 0 is the top word of a block
    function automatic aes_word_t block_word(input aes_block_t b, input int w);
        return b[`AES_BLOCK_W-1-`AES_WORD_W*w -: `AES_WORD_W];
    endfunction

    task automatic wait_clk();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_until_cycle(input int c);
        while (cycle_cnt < c) wait_clk();
    endtask

    task automatic check_value(input string name, input aes_word_t expected,
                               input aes_word_t actual);
        num_checks++;
        assert (actual === expected)
        else begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        num_checks++;
        assert (cond === 1'b1)
        else begin
            other_errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    // start one cycle ahead of the four words
    task automatic send_block(input aes_block_t text, input aes_block_t key,
                              output int start_cyc);
        start_cyc = cycle_cnt + 1; // edge that samples start
        start     = 1'b1;
        wait_clk();
        start = 1'b0;
        for (int w = 0; w < `AES_WORDS_PER_BLOCK; w++) begin
            input_text = block_word(text, w);
            input_key  = block_word(key, w);
            wait_clk();
        end
        input_text = '0;
        input_key  = '0;
    endtask

    task automatic expect_block(input aes_block_t expected, input int start_cyc,
                                input string tag);
        while (cycle_cnt < start_cyc + RESULT_LATENCY) begin
            check_true(!done, {tag, ": done rose before the result was due"});
            check_value("output_text", '0, output_text);
            wait_clk();
        end
        check_true(done, {tag, ": done missing 16 cycles after start"});
        for (int w = 0; w < `AES_WORDS_PER_BLOCK; w++) begin
            if (w > 0) check_true(done, {tag, ": done dropped inside the output window"});
            check_value($sformatf("%s output_text word %0d", tag, w),
                        block_word(expected, w), output_text);
            wait_clk();
        end
        check_true(!done, {tag, ": done stayed high past four cycles"});
        check_value("output_text", '0, output_text);
    endtask

    task automatic watch_idle(input int n, input string tag);
        repeat (n) begin
            check_true(!done, {tag, ": unexpected done"});
            check_value("output_text", '0, output_text);
            wait_clk();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_fips_c1();
        int s;
        $display("test 1: fips-197 c.1 vector");
        send_block(C1_TEXT, C1_KEY, s);
        expect_block(C1_CIPHER, s, "c.1");
    endtask

    task automatic test_fips_b();
        int s;
        $display("test 2: fips-197 appendix b vector");
        watch_idle(2, "before b");
        send_block(B_TEXT, B_KEY, s);
        expect_block(B_CIPHER, s, "appendix b");
        watch_idle(2, "after b");
    endtask

    task automatic test_start_while_busy();
        int first_cyc;
        int ignored_cyc;
        $display("test 3: start ignored while busy");
        send_block(C1_TEXT, C1_KEY, first_cyc);
        wait_until_cycle(first_cyc + 6); // second start lands at cycle 7
        send_block(128'hffeeddccbbaa99887766554433221100,
                   128'h0f0e0d0c0b0a09080706050403020100, ignored_cyc);
        expect_block(C1_CIPHER, first_cyc, "busy start");
        // a block taken from the second start would show up in this window
        watch_idle(ignored_cyc + RESULT_LATENCY + `AES_WORDS_PER_BLOCK - cycle_cnt,
                   "second start");
    endtask

    task automatic test_back_to_back();
        int s;
        int gap;
        $display("test 4: back-to-back blocks");
        for (int i = 0; i < 4; i++) begin
            if (i % 2 == 0) begin
                send_block(C1_TEXT, C1_KEY, s);
                expect_block(C1_CIPHER, s, $sformatf("block %0d c.1", i));
            end else begin
                send_block(B_TEXT, B_KEY, s);
                expect_block(B_CIPHER, s, $sformatf("block %0d b", i));
            end
            take_random_bits(3, gap); // 0 to 7 idle cycles
            repeat (gap) wait_clk();
        end
    endtask

    task automatic test_reset_mid_block();
        int s;
        $display("test 5: reset during a block");
        send_block(C1_TEXT, C1_KEY, s);
        wait_until_cycle(s + 8);
        rst_n = 1'b0; // asynchronous, inside cycle 9
        repeat (2) begin
            wait_clk();
            check_true(!done, "done high while in reset");
            check_value("output_text", '0, output_text);
        end
        rst_n = 1'b1;
        watch_idle(20, "aborted block");
        send_block(B_TEXT, B_KEY, s);
        expect_block(B_CIPHER, s, "after reset");
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        input_text = '0;
        input_key  = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_true(!done, "done high after reset");
        check_value("output_text", '0, output_text);

        test_fips_c1();
        test_fips_b();
        test_start_while_busy();
        test_back_to_back();
        test_reset_mid_block();

        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 num_checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/aes_pkg.sv
verilog/aes_block_loader.sv
verilog/aes_key_schedule.sv
verilog/aes_round_engine.sv
verilog/aes_output_serializer.sv
verilog/aes_encrypt_top.sv
testbench/aes_encrypt_tb.sv

/* Makefile */
# Verilator build and run for the AES-128 core testbench

VERILATOR   ?= verilator
TOP         ?= aes_encrypt_tb
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
JOBS        ?= 4
EXTRA_FLAGS ?=

FAIL_MSG := TESTBENCH FAILED
PASS_MSG := TESTBENCH PASSED
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --assert --timing -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST) $(EXTRA_FLAGS)

# the log decides the result, the simulator exit code is not trusted
run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
